/* design/cdc_pkg.sv */
// default widths and depths for the slow signal clock crossing
package cdc_pkg;

    // width of the status word carried into the clk_dst domain
    localparam int STATUS_W = 8;

    // value of the status word after reset and while the crossed reset is active
    localparam logic [STATUS_W-1:0] STATUS_INIT = '0;

    // clk_dst flops after the clk_src capture flop
    // two is the minimum for metastability settling
    localparam int SYNC_STAGES = 3;

    // duplication stages behind the reset synchronizer
    // values below 2 are raised to 2 inside the reset crossing
    localparam int TREE_DEPTH = 4;

    // consecutive clk_dst cycles a sample must hold before it is accepted
    // this filters torn multi-bit samples and short glitches on status_in
    localparam int STABLE_CYCLES = 4;

endpackage

/* design/cdc_status_crossing.sv */
// capture register and clk_dst synchronizer chain for slowly changing levels
`timescale 1ns/1ns

module cdc_status_crossing
    import cdc_pkg::*;
#(
    parameter int WIDTH = STATUS_W,
    parameter logic [WIDTH-1:0] INITIAL_VALUE = STATUS_INIT,
    parameter int SYNC_STAGES = cdc_pkg::SYNC_STAGES
)
(
    input  logic             clk_src,
    input  logic             clk_dst,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] r_in,
    output logic [WIDTH-1:0] r_out
);

    // source side capture, isolates r_in logic from the crossing
    logic [WIDTH-1:0] capture_q;

    // destination chain, stage 0 is the one that may go metastable
    logic [WIDTH-1:0] sync_q [SYNC_STAGES];

    always_ff @(posedge clk_src or negedge rst_n)
    begin
        if (!rst_n)
        begin
            capture_q <= INITIAL_VALUE;
        end
        else
        begin
            capture_q <= r_in;
        end
    end

    // plain shift, no logic between stages
    always_ff @(posedge clk_dst or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= INITIAL_VALUE;
            end
        end
        else
        begin
            sync_q[0] <= capture_q;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // bits of a vector may land on different cycles
    // the qualifier downstream waits for the word to settle
    assign r_out = sync_q[SYNC_STAGES-1];

    // a single flop leaves no settling time before use
    a_min_sync_stages : assert property (@(posedge clk_dst) SYNC_STAGES >= 2)
        else $error("cdc_status_crossing needs at least 2 sync stages");

endmodule

/* design/cdc_reset_crossing.sv */
// reset crossing through the status synchronizer and a duplication shift tree
`timescale 1ns/1ns

module cdc_reset_crossing
    import cdc_pkg::*;
#(
    parameter int TREE_DEPTH = cdc_pkg::TREE_DEPTH,
    parameter int SYNC_STAGES = cdc_pkg::SYNC_STAGES
)
(
    input  logic clk_src,
    input  logic clk_dst,
    input  logic rst_n,
    input  logic reset_in_n,
    output logic reset_out_n
);

    // tree needs at least two stages so the slice below stays legal
    localparam int DEPTH = (TREE_DEPTH >= 2) ? TREE_DEPTH : 2;

    // synchronized reset request while still a single register
    logic reset_cc_n;

    // shift stages that tools may replicate for fanout
    logic [DEPTH-1:0] dup_tree;

    // final stage feeding every reset load in clk_dst
    logic dup_leaf;

    // active state is the initial value, so the domain starts in reset
    cdc_status_crossing #(
        .WIDTH         (1),
        .INITIAL_VALUE (1'b0),
        .SYNC_STAGES   (SYNC_STAGES)
    ) reset_sync_inst (
        .clk_src (clk_src),
        .clk_dst (clk_dst),
        .rst_n   (rst_n),
        .r_in    (reset_in_n),
        .r_out   (reset_cc_n)
    );

    // assert and release both walk the full tree
    // adds DEPTH+1 clk_dst cycles to the crossing latency
    always_ff @(posedge clk_dst or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dup_tree <= '0;
            dup_leaf <= 1'b0;
        end
        else
        begin
            dup_tree <= {dup_tree[DEPTH-2:0], reset_cc_n};
            dup_leaf <= dup_tree[DEPTH-1];
        end
    end

    assign reset_out_n = dup_leaf;

    // leaf rises only while the tail stage is high as well
    a_release_from_tree : assert property (
        @(posedge clk_dst) disable iff (!rst_n)
        $rose(reset_out_n) |-> dup_tree[DEPTH-1]
    ) else $error("reset_out_n released while tree tail was low");

endmodule

/* design/cdc_status_qualifier.sv */
// stability filter, reset gating and change strobe for the crossed status word
`timescale 1ns/1ns

module cdc_status_qualifier
    import cdc_pkg::*;
#(
    parameter int WIDTH = STATUS_W,
    parameter logic [WIDTH-1:0] INITIAL_VALUE = STATUS_INIT,
    parameter int STABLE_CYCLES = cdc_pkg::STABLE_CYCLES
)
(
    input  logic             clk_dst,
    input  logic             rst_n,
    input  logic             dst_reset_n,
    input  logic [WIDTH-1:0] sync_status,
    output logic [WIDTH-1:0] status_out,
    output logic             status_change
);

    // counter must reach STABLE_CYCLES+1 for the saturation compare
    localparam int CNT_W = $clog2(STABLE_CYCLES + 2);
    localparam logic [CNT_W-1:0] CNT_TARGET = CNT_W'(STABLE_CYCLES);

    // sample seen on the previous clk_dst edge
    logic [WIDTH-1:0] sample_q;

    // edges the current sample has held up to the target
    logic [CNT_W-1:0] stable_cnt;

    // run length including the sample on this edge
    logic [CNT_W-1:0] run_len;

    logic sample_same;
    logic accept;
    logic differs;

    assign sample_same = (sync_status == sample_q);

    // any difference restarts the run at one
    assign run_len = sample_same ? (stable_cnt + 1'b1) : CNT_W'(1);

    // exact compare so a held word is taken once and not every cycle
    assign accept = (run_len == CNT_TARGET);

    assign differs = (sync_status != status_out);

    // stability tracking
    // crossed reset parks the filter so the held input restarts its run on release
    always_ff @(posedge clk_dst or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sample_q   <= INITIAL_VALUE;
            stable_cnt <= '0;
        end
        else if (!dst_reset_n)
        begin
            sample_q   <= INITIAL_VALUE;
            stable_cnt <= '0;
        end
        else
        begin
            sample_q <= sync_status;
            if (run_len > CNT_TARGET)
            begin
                stable_cnt <= CNT_TARGET;
            end
            else
            begin
                stable_cnt <= run_len;
            end
        end
    end

    // accepted word and strobe
    // strobe and status_out update on the same edge
    always_ff @(posedge clk_dst or negedge rst_n)
    begin
        if (!rst_n)
        begin
            status_out    <= INITIAL_VALUE;
            status_change <= 1'b0;
        end
        else if (!dst_reset_n)
        begin
            // forced value is not a change seen by the consumer
            status_out    <= INITIAL_VALUE;
            status_change <= 1'b0;
        end
        else
        begin
            status_change <= 1'b0;
            if (accept)
            begin
                status_out    <= sync_status;
                status_change <= differs;
            end
        end
    end

    // a new accept needs STABLE_CYCLES edges, so pulses cannot touch
    a_single_cycle_pulse : assert property (
        @(posedge clk_dst) disable iff (!rst_n)
        status_change |=> !status_change
    ) else $error("status_change held for more than one cycle");

    // strobe stays low in every cycle the crossed reset is active
    a_no_pulse_in_reset : assert property (
        @(posedge clk_dst) disable iff (!rst_n)
        !dst_reset_n |-> !status_change
    ) else $error("status_change raised during crossed reset");

endmodule

/* design/slow_signal_cdc.sv */
// top level joining the status crossing, reset crossing and status qualifier
`timescale 1ns/1ns

module slow_signal_cdc
    import cdc_pkg::*;
#(
    parameter int STATUS_W = cdc_pkg::STATUS_W,
    parameter logic [STATUS_W-1:0] STATUS_INIT = cdc_pkg::STATUS_INIT,
    parameter int SYNC_STAGES = cdc_pkg::SYNC_STAGES,
    parameter int TREE_DEPTH = cdc_pkg::TREE_DEPTH,
    parameter int STABLE_CYCLES = cdc_pkg::STABLE_CYCLES
)
(
    input  logic                clk_src,
    input  logic                clk_dst,
    input  logic                rst_n,
    input  logic                src_reset_n,
    input  logic [STATUS_W-1:0] status_in,
    output logic [STATUS_W-1:0] status_out,
    output logic                status_change,
    output logic                dst_reset_n
);

    // raw crossed word, bits may still disagree for a cycle
    logic [STATUS_W-1:0] sync_status;

    // status word path into clk_dst
    cdc_status_crossing #(
        .WIDTH         (STATUS_W),
        .INITIAL_VALUE (STATUS_INIT),
        .SYNC_STAGES   (SYNC_STAGES)
    ) status_crossing_inst (
        .clk_src (clk_src),
        .clk_dst (clk_dst),
        .rst_n   (rst_n),
        .r_in    (status_in),
        .r_out   (sync_status)
    );

    // source reset request into clk_dst
    // output also leaves the top for other clk_dst logic
    cdc_reset_crossing #(
        .TREE_DEPTH  (TREE_DEPTH),
        .SYNC_STAGES (SYNC_STAGES)
    ) reset_crossing_inst (
        .clk_src     (clk_src),
        .clk_dst     (clk_dst),
        .rst_n       (rst_n),
        .reset_in_n  (src_reset_n),
        .reset_out_n (dst_reset_n)
    );

    // filters the crossed word and gates it with the crossed reset
    cdc_status_qualifier #(
        .WIDTH         (STATUS_W),
        .INITIAL_VALUE (STATUS_INIT),
        .STABLE_CYCLES (STABLE_CYCLES)
    ) status_qualifier_inst (
        .clk_dst       (clk_dst),
        .rst_n         (rst_n),
        .dst_reset_n   (dst_reset_n),
        .sync_status   (sync_status),
        .status_out    (status_out),
        .status_change (status_change)
    );

endmodule

/* testbench/slow_signal_cdc_tb.sv */
// clock generation, directed tests, value checker and watchdog for the slow signal crossing
`timescale 1ns/1ns

module slow_signal_cdc_tb
    import cdc_pkg::*;
();

    localparam int CLK_DST_PERIOD = 10;
    localparam int CLK_SRC_PERIOD = 14;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_COUNT = 20;

    // one clk_src period rounded up to whole clk_dst cycles
    localparam int SRC_IN_DST = (CLK_SRC_PERIOD + CLK_DST_PERIOD - 1) / CLK_DST_PERIOD;

    // capture edge, phase slip, chain and stability run plus two cycles of slack
    localparam int STATUS_BOUND = SRC_IN_DST + SYNC_STAGES + 1 + STABLE_CYCLES + 2;

    // same crossing followed by the tree stages and the leaf flop
    localparam int RESET_BOUND = SRC_IN_DST + SYNC_STAGES + 1 + TREE_DEPTH + 1 + 2;

    // clk_dst cycles each test may take including clk_src edge waits
    localparam int RESET_TEST_LEN = RESET_CYCLES + 2 + RESET_BOUND + STATUS_BOUND;
    localparam int CHANGE_TEST_LEN = 2 * SRC_IN_DST + 3 * STATUS_BOUND;
    localparam int GLITCH_TEST_LEN = 2 * SRC_IN_DST + STATUS_BOUND;
    localparam int GATING_TEST_LEN = 2 * SRC_IN_DST + 2 * RESET_BOUND + 1 + 2 * STATUS_BOUND;
    localparam int RANDOM_TEST_LEN = RANDOM_COUNT * (SRC_IN_DST + 2 * STATUS_BOUND);
    localparam int TOTAL_CYCLES = RESET_TEST_LEN + CHANGE_TEST_LEN + GLITCH_TEST_LEN
                                + GATING_TEST_LEN + RANDOM_TEST_LEN;

    // twice the summed test lengths
    localparam int WATCHDOG_NS = 2 * TOTAL_CYCLES * CLK_DST_PERIOD;

    // nonzero word for the directed tests so it differs from STATUS_INIT
    localparam logic [STATUS_W-1:0] TEST_WORD = STATUS_W'(32'h5a);

    logic                clk_src;
    logic                clk_dst;
    logic                rst_n;
    logic                src_reset_n;
    logic [STATUS_W-1:0] status_in;
    logic [STATUS_W-1:0] status_out;
    logic                status_change;
    logic                dst_reset_n;

    slow_signal_cdc slow_signal_cdc_inst (
        .clk_src       (clk_src),
        .clk_dst       (clk_dst),
        .rst_n         (rst_n),
        .src_reset_n   (src_reset_n),
        .status_in     (status_in),
        .status_out    (status_out),
        .status_change (status_change),
        .dst_reset_n   (dst_reset_n)
    );

    // destination clock
    initial
    begin
        clk_dst = 1'b0;
        forever #(CLK_DST_PERIOD / 2) clk_dst = ~clk_dst;
    end

    // source clock with an unrelated period so the phase keeps sliding
    initial
    begin
        clk_src = 1'b0;
        forever #(CLK_SRC_PERIOD / 2) clk_src = ~clk_src;
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error %s expected %0h actual %0h", test_name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch in test %s", test_name);
        end
    endtask

    // source side inputs move on clk_src edges only
    task automatic drive_status(input logic [STATUS_W-1:0] value);
        @(posedge clk_src);
        status_in <= value;
    endtask

    task automatic drive_src_reset(input logic level);
        @(posedge clk_src);
        src_reset_n <= level;
    endtask

    // samples on the falling clk_dst edge away from output updates
    task automatic wait_for_status(input string test_name, input logic [STATUS_W-1:0] expected,
                                   input int bound, inout int pulses);
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk_dst);
            if (status_change === 1'b1)
            begin
                pulses++;
            end
            waited++;
        end
        while (status_out !== expected && waited < bound);
        check_value(test_name, 32'(expected), 32'(status_out));
    endtask

    task automatic wait_for_reset(input string test_name, input logic level,
                                  input int bound, inout int pulses);
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk_dst);
            if (status_change === 1'b1)
            begin
                pulses++;
            end
            waited++;
        end
        while (dst_reset_n !== level && waited < bound);
        check_value(test_name, 32'(level), 32'(dst_reset_n));
    endtask

    // status_out must not move for the whole window
    task automatic observe_hold(input string test_name, input int cycles,
                                input logic [STATUS_W-1:0] hold_value, inout int pulses);
        repeat (cycles)
        begin
            @(negedge clk_dst);
            check_value(test_name, 32'(hold_value), 32'(status_out));
            if (status_change === 1'b1)
            begin
                pulses++;
            end
        end
    endtask

    task automatic reset_state_test();
        int pulses;
        pulses = 0;
        // every clk_dst flop parked while rst_n is low
        repeat (RESET_CYCLES)
        begin
            @(negedge clk_dst);
            check_value("reset_state", 32'(STATUS_INIT), 32'(status_out));
            check_value("reset_state", 32'd0, 32'(status_change));
            check_value("reset_state", 32'd0, 32'(dst_reset_n));
        end
        @(posedge clk_dst);
        rst_n <= 1'b1;
        // first cycle after release with the crossed reset still held
        @(negedge clk_dst);
        check_value("reset_state", 32'(STATUS_INIT), 32'(status_out));
        check_value("reset_state", 32'd0, 32'(status_change));
        check_value("reset_state", 32'd0, 32'(dst_reset_n));
        wait_for_reset("reset_state", 1'b1, RESET_BOUND, pulses);
        observe_hold("reset_state", STATUS_BOUND, STATUS_INIT, pulses);
        check_value("reset_state", 32'd0, pulses);
    endtask

    task automatic slow_change_test(input logic [STATUS_W-1:0] value);
        int pulses;
        pulses = 0;
        drive_status(value);
        wait_for_status("slow_change", value, STATUS_BOUND, pulses);
        observe_hold("slow_change", STATUS_BOUND, value, pulses);
        check_value("slow_change", 32'd1, pulses);
        // rewriting the held word gives the consumer nothing new
        pulses = 0;
        drive_status(value);
        observe_hold("same_value", STATUS_BOUND, value, pulses);
        check_value("same_value", 32'd0, pulses);
    endtask

    task automatic glitch_filter_test(input logic [STATUS_W-1:0] base);
        int pulses;
        pulses = 0;
        // one clk_src cycle covers at most two clk_dst samples
        drive_status(~base);
        drive_status(base);
        observe_hold("glitch_filter", STATUS_BOUND, base, pulses);
        check_value("glitch_filter", 32'd0, pulses);
    endtask

    task automatic reset_gating_test(input logic [STATUS_W-1:0] held);
        int pulses;
        int expected_pulses;
        pulses = 0;
        drive_src_reset(1'b0);
        wait_for_reset("reset_gating", 1'b0, RESET_BOUND, pulses);
        // qualifier forces its output one edge after the crossed reset falls
        @(negedge clk_dst);
        check_value("reset_gating", 32'(STATUS_INIT), 32'(status_out));
        check_value("reset_gating", 32'd0, 32'(status_change));
        check_value("reset_gating", 32'd0, pulses);
        drive_src_reset(1'b1);
        wait_for_reset("reset_gating", 1'b1, RESET_BOUND, pulses);
        // status_in was never changed, so the held word comes back
        wait_for_status("reset_gating", held, STATUS_BOUND, pulses);
        observe_hold("reset_gating", STATUS_BOUND, held, pulses);
        expected_pulses = (held != STATUS_INIT) ? 1 : 0;
        check_value("reset_gating", 32'(expected_pulses), pulses);
    endtask

    task automatic random_sequence_test(input logic [STATUS_W-1:0] start_value);
        logic [STATUS_W-1:0] prev_value;
        logic [STATUS_W-1:0] next_value;
        int idx;
        int pulses;
        int expected_pulses;
        prev_value = start_value;
        for (idx = 0; idx < RANDOM_COUNT; idx++)
        begin
            // roughly one in four repeats its predecessor
            if ($urandom_range(0, 3) == 0)
            begin
                next_value = prev_value;
            end
            else
            begin
                next_value = STATUS_W'($urandom());
            end
            pulses = 0;
            drive_status(next_value);
            wait_for_status("random_sequence", next_value, STATUS_BOUND, pulses);
            observe_hold("random_sequence", STATUS_BOUND, next_value, pulses);
            expected_pulses = (next_value != prev_value) ? 1 : 0;
            check_value("random_sequence", 32'(expected_pulses), pulses);
            prev_value = next_value;
        end
    endtask

    initial
    begin
        void'($urandom(32'h4448_f195));
        rst_n       = 1'b0;
        src_reset_n = 1'b1;
        status_in   = STATUS_INIT;
        reset_state_test();
        slow_change_test(TEST_WORD);
        glitch_filter_test(TEST_WORD);
        reset_gating_test(TEST_WORD);
        random_sequence_test(TEST_WORD);
        $display("Simulation passed");
        $finish;
    end

    // ends a run that stalls in any wait
    initial
    begin
        #(WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

endmodule

/* slow_signal_cdc.f */
design/cdc_pkg.sv
design/cdc_status_crossing.sv
design/cdc_reset_crossing.sv
design/cdc_status_qualifier.sv
design/slow_signal_cdc.sv
testbench/slow_signal_cdc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status of the simulation binary is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module slow_signal_cdc_tb \
    -f slow_signal_cdc.f

./obj_dir/Vslow_signal_cdc_tb
